/* tape_pkg.sv */
package tape_pkg;

   typedef logic [31:0] word_t;         // bus and memory word
   typedef logic signed [15:0] sample_t;
   typedef logic [13:0] ptr_t;          // ring pointer in words
   typedef logic [10:0] rate_t;         // sample period minus one

   typedef struct packed {
      logic  playing;
      logic  stereo;
      logic  fmt_16bit;
      rate_t sample_rate;
   } tape_cfg_t;

   typedef struct packed {
      logic [7:0] data;
      logic       cs2;
      logic       cs1;
   } mag_entry_t;

   // register word offsets, addr[1:0]
   localparam logic [1:0] reg_ctrl = 2'd0;
   localparam logic [1:0] reg_ptrs = 2'd1;
   localparam logic [1:0] reg_size = 2'd2;
   localparam logic [1:0] reg_mag  = 2'd3;

   // tape pulse windows in ticks
   localparam int short_min = 2;
   localparam int long_min  = 6;
   localparam int long_max  = 12;

   localparam int sync_zeros = 32;      // leader zeros needed for sync

endpackage

/* tape_regs.sv */
`timescale 1ns/1ps

module tape_regs #(
   parameter int mem_words = 2048
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cs,
   input  logic                  we,
   input  logic [3:0]            sel,
   input  logic [13:0]           addr,
   input  tape_pkg::word_t       wdata,
   output tape_pkg::word_t       rdata,
   input  logic                  cs1,
   input  logic                  cs2,
   output tape_pkg::tape_cfg_t   cfg,
   output tape_pkg::ptr_t        tail,
   output logic                  head_load,
   output tape_pkg::ptr_t        head_value,
   input  tape_pkg::ptr_t        head,
   output logic                  wr_en,
   output tape_pkg::ptr_t        wr_addr,
   output logic [3:0]            wr_sel,
   output tape_pkg::word_t       wr_data,
   output logic                  pop,
   input  tape_pkg::mag_entry_t  fifo_head,
   input  logic                  fifo_empty,
   input  logic                  fifo_lost
);

   logic       reg_wr;
   logic       reg_rd;
   logic [1:0] offset;

   assign offset = addr[1:0];
   assign reg_wr = cs & we & addr[13];
   assign reg_rd = cs & ~we & addr[13];

   // sample memory port, write only from the bus
   assign wr_en   = cs & we & ~addr[13];
   assign wr_addr = addr;
   assign wr_sel  = sel;
   assign wr_data = wdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg  <= '{playing: 1'b0, stereo: 1'b0, fmt_16bit: 1'b0, sample_rate: '1};
         tail <= '0;
      end else if (reg_wr) begin
         if (offset == tape_pkg::reg_ctrl) begin
            if (sel[0])
               cfg.sample_rate[7:0] <= wdata[7:0];
            if (sel[1]) begin
               cfg.playing            <= wdata[15];
               cfg.stereo             <= wdata[14];
               cfg.fmt_16bit          <= wdata[13];
               cfg.sample_rate[10:8]  <= wdata[10:8];
            end
         end
         if (offset == tape_pkg::reg_ptrs) begin
            if (sel[2])
               tail[7:0] <= wdata[23:16];
            if (sel[3])
               tail[13:8] <= wdata[29:24];
         end
      end
   end

   // head lives in the player, lanes merged with its current value
   assign head_load  = reg_wr & (offset == tape_pkg::reg_ptrs) & (sel[0] | sel[1]);
   assign head_value = {sel[1] ? wdata[13:8] : head[13:8],
                        sel[0] ? wdata[7:0]  : head[7:0]};

   assign pop = reg_rd & (offset == tape_pkg::reg_mag) & ~fifo_empty;

   always_comb begin
      rdata = '0;
      if (addr[13]) begin
         case (offset)
            tape_pkg::reg_ctrl: begin
               rdata[15]   = cfg.playing;
               rdata[14]   = cfg.stereo;
               rdata[13]   = cfg.fmt_16bit;
               rdata[10:0] = cfg.sample_rate;
            end
            tape_pkg::reg_ptrs: begin
               rdata[13:0]  = head;
               rdata[29:16] = tail;
            end
            tape_pkg::reg_size: rdata = tape_pkg::word_t'(mem_words);
            default: begin
               rdata[7:0] = fifo_head.data;
               rdata[8]   = ~fifo_empty;      // valid
               rdata[9]   = fifo_lost;
               rdata[10]  = fifo_head.cs1;
               rdata[11]  = fifo_head.cs2;
               rdata[12]  = cs1;              // live motor lines
               rdata[13]  = cs2;
            end
         endcase
      end
   end

endmodule

/* tape_sample_ram.sv */
`timescale 1ns/1ps

module tape_sample_ram #(
   parameter int mem_words = 2048
) (
   input  logic             clk,
   input  logic             wr_en,
   input  tape_pkg::ptr_t   wr_addr,
   input  logic [3:0]       wr_sel,
   input  tape_pkg::word_t  wr_data,
   input  logic             rd_en,
   input  tape_pkg::ptr_t   rd_addr,
   output tape_pkg::word_t  rd_data
);

   localparam int aw = $clog2(mem_words);

   logic [aw-1:0] wr_index;
   logic [aw-1:0] rd_index;

   assign wr_index = wr_addr[aw-1:0];   // ring wraps on low bits
   assign rd_index = rd_addr[aw-1:0];

   for (genvar lane = 0; lane < 4; lane++) begin : g_lane
      logic [7:0] mem [mem_words];

      always_ff @(posedge clk) begin
         if (wr_en && wr_sel[lane])
            mem[wr_index] <= wr_data[lane*8 +: 8];
      end

      always_ff @(posedge clk) begin
         if (rd_en)
            rd_data[lane*8 +: 8] <= mem[rd_index];
      end
   end

endmodule

/* tape_player.sv */
`timescale 1ns/1ps

module tape_player (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 tick_en,
   input  logic                 cs1,
   input  tape_pkg::tape_cfg_t  cfg,
   input  tape_pkg::ptr_t       tail,
   input  logic                 head_load,
   input  tape_pkg::ptr_t       head_value,
   output tape_pkg::ptr_t       head,
   output logic                 rd_en,
   output tape_pkg::ptr_t       rd_addr,
   input  tape_pkg::word_t      rd_data,
   output tape_pkg::sample_t    audio
);

   typedef enum logic [1:0] {
      st_empty,
      st_fetch,
      st_full
   } buf_state_t;

   buf_state_t         state;
   tape_pkg::word_t    buffer;
   tape_pkg::rate_t    rate_cnt;
   logic [1:0]         left;         // samples left after the current one
   logic               advance;
   tape_pkg::sample_t  next_sample;

   assign rd_en   = cfg.playing && state == st_empty && head != tail;
   assign rd_addr = head;
   assign advance = cfg.playing & tick_en & cs1 & (rate_cnt == '0) & (state == st_full);

   always_comb begin
      if (cfg.stereo)
         next_sample = buffer[15:0] + buffer[31:16];   // wraps to 16 bits
      else if (cfg.fmt_16bit)
         next_sample = buffer[15:0];
      else
         next_sample = {~buffer[7], buffer[6:0], buffer[7:0]};
   end

   always_ff @(posedge clk) begin
      if (reset)
         head <= '0;
      else if (head_load)
         head <= head_value;
      else if (rd_en)
         head <= head + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_empty;
         rate_cnt <= '0;
         left     <= '0;
         audio    <= '0;
      end else if (!cfg.playing) begin
         state    <= st_empty;       // drop buffered word
         rate_cnt <= '0;
         audio    <= '0;
      end else begin
         if (rd_en)
            state <= st_fetch;
         if (state == st_fetch) begin
            state <= st_full;
            if (cfg.stereo)
               left <= 2'd0;
            else if (cfg.fmt_16bit)
               left <= 2'd1;
            else
               left <= 2'd3;
         end
         if (tick_en) begin
            if (!cs1)
               audio <= '0;          // motor off, position kept
            else if (rate_cnt != '0)
               rate_cnt <= rate_cnt - 1'b1;
            else
               rate_cnt <= cfg.sample_rate;
         end
         if (advance) begin
            audio <= next_sample;
            left  <= left - 1'b1;
            if (left == 2'd0)
               state <= st_empty;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_fetch)
         buffer <= rd_data;
      else if (advance)
         buffer <= cfg.fmt_16bit ? buffer >> 16 : buffer >> 8;   // lowest sample first
   end

endmodule

/* tape_mag_decoder.sv */
`timescale 1ns/1ps

module tape_mag_decoder (
   input  logic        clk,
   input  logic        reset,
   input  logic        tick_en,
   input  logic        mag_in,
   output logic        byte_valid,
   output logic [7:0]  byte_data
);

   localparam int cnt_w  = $clog2(tape_pkg::long_max + 1);
   localparam int zero_w = $clog2(tape_pkg::sync_zeros + 1);

   typedef enum logic {
      st_hunt,
      st_synced
   } sync_state_t;

   sync_state_t        state;
   logic               mag_last;
   logic               half_seen;    // first short of a 1 bit seen
   logic [cnt_w-1:0]   tick_cnt;
   logic [cnt_w:0]     ivl;
   logic [zero_w-1:0]  zero_cnt;
   logic [2:0]         bit_cnt;
   logic [6:0]         shift;
   logic               edge_seen;
   logic               is_long;
   logic               is_short;
   logic               bit_done;
   logic               bit_val;
   logic               drop;

   assign edge_seen = tick_en & (mag_in != mag_last);
   assign ivl       = {1'b0, tick_cnt} + 1'b1;
   assign is_long   = ivl >= tape_pkg::long_min && ivl <= tape_pkg::long_max;
   assign is_short  = ivl >= tape_pkg::short_min && ivl < tape_pkg::long_min;

   always_comb begin
      bit_done = 1'b0;
      bit_val  = 1'b0;
      drop     = 1'b0;
      if (edge_seen) begin
         if (is_long && !half_seen) begin
            bit_done = 1'b1;
         end else if (is_short && half_seen) begin
            bit_done = 1'b1;
            bit_val  = 1'b1;
         end else if (!is_short) begin
            drop = 1'b1;             // bad interval
         end
      end else if (tick_en && tick_cnt == cnt_w'(tape_pkg::long_max)) begin
         drop = 1'b1;                // tape went quiet
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_hunt;
         mag_last   <= 1'b0;
         half_seen  <= 1'b0;
         tick_cnt   <= '0;
         zero_cnt   <= '0;
         bit_cnt    <= '0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         if (tick_en) begin
            mag_last <= mag_in;
            if (edge_seen)
               tick_cnt <= '0;
            else if (tick_cnt != cnt_w'(tape_pkg::long_max))
               tick_cnt <= tick_cnt + 1'b1;
         end
         if (drop) begin
            state     <= st_hunt;
            zero_cnt  <= '0;
            half_seen <= 1'b0;
         end else if (edge_seen && is_short) begin
            half_seen <= ~half_seen;
         end
         if (bit_done) begin
            if (state == st_synced) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7)
                  byte_valid <= 1'b1;
            end else if (bit_val) begin
               if (zero_cnt == zero_w'(tape_pkg::sync_zeros)) begin
                  state   <= st_synced;   // leader done, start bit seen
                  bit_cnt <= '0;
               end else begin
                  zero_cnt <= '0;
               end
            end else if (zero_cnt != zero_w'(tape_pkg::sync_zeros)) begin
               zero_cnt <= zero_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bit_done && state == st_synced) begin
         shift <= {shift[5:0], bit_val};       // msb first
         if (bit_cnt == 3'd7)
            byte_data <= {shift, bit_val};
      end
   end

endmodule

/* tape_byte_fifo.sv */
`timescale 1ns/1ps

module tape_byte_fifo #(
   parameter int fifo_depth = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  tape_pkg::mag_entry_t  push_entry,
   input  logic                  pop,
   output tape_pkg::mag_entry_t  head_entry,
   output logic                  empty,
   output logic                  lost
);

   tape_pkg::mag_entry_t   mem [fifo_depth];
   tape_pkg::mag_entry_t   mem_up [fifo_depth];
   logic [fifo_depth-1:0]  occ;          // thermometer, slot 0 is the head
   logic [fifo_depth-1:0]  occ_sh;
   logic [fifo_depth-1:0]  fill;

   always_comb begin
      occ_sh = pop ? occ >> 1 : occ;
      fill   = {fifo_depth{push}} & ~occ_sh & {occ_sh[fifo_depth-2:0], 1'b1};
      for (int i = 0; i < fifo_depth - 1; i++)
         mem_up[i] = mem[i+1];
      mem_up[fifo_depth-1] = mem[fifo_depth-1];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         occ  <= '0;
         lost <= 1'b0;
      end else begin
         occ <= occ_sh | fill;
         if (pop)
            lost <= 1'b0;
         else if (push && occ[fifo_depth-1])
            lost <= 1'b1;            // full, byte dropped
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < fifo_depth; i++) begin
         if (fill[i])
            mem[i] <= push_entry;
         else if (pop)
            mem[i] <= mem_up[i];
      end
   end

   assign head_entry = mem[0];
   assign empty      = ~occ[0];

endmodule

/* tape_mmio.sv */
`timescale 1ns/1ps

module tape_mmio #(
   parameter int mem_words  = 2048,
   parameter int fifo_depth = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               tick_en,
   input  logic               cs,
   input  logic               we,
   input  logic [3:0]         sel,
   input  logic [13:0]        addr,
   input  tape_pkg::word_t    wdata,
   output tape_pkg::word_t    rdata,
   input  logic               cs1,
   input  logic               cs2,
   input  logic               mag_in,
   output tape_pkg::sample_t  audio
);

   if (mem_words < 256 || mem_words > 16384 || (mem_words & (mem_words - 1)) != 0) begin
      : g_bad_size
      $fatal(1, "mem_words must be a power of two from 256 to 16384");
   end

   tape_pkg::tape_cfg_t   cfg;
   tape_pkg::ptr_t        tail;
   tape_pkg::ptr_t        head;
   tape_pkg::ptr_t        head_value;
   logic                  head_load;
   logic                  wr_en;
   tape_pkg::ptr_t        wr_addr;
   logic [3:0]            wr_sel;
   tape_pkg::word_t       wr_data;
   logic                  rd_en;
   tape_pkg::ptr_t        rd_addr;
   tape_pkg::word_t       rd_data;
   logic                  pop;
   tape_pkg::mag_entry_t  fifo_head;
   logic                  fifo_empty;
   logic                  fifo_lost;
   logic                  byte_valid;
   logic [7:0]            byte_data;
   tape_pkg::mag_entry_t  push_entry;

   assign push_entry = '{data: byte_data, cs2: cs2, cs1: cs1};   // motor state at byte end

   tape_regs #(.mem_words(mem_words)) u_regs (
      .clk, .reset, .cs, .we, .sel, .addr, .wdata, .rdata, .cs1, .cs2,
      .cfg, .tail, .head_load, .head_value, .head,
      .wr_en, .wr_addr, .wr_sel, .wr_data,
      .pop, .fifo_head, .fifo_empty, .fifo_lost
   );

   tape_sample_ram #(.mem_words(mem_words)) u_ram (
      .clk, .wr_en, .wr_addr, .wr_sel, .wr_data, .rd_en, .rd_addr, .rd_data
   );

   tape_player u_player (
      .clk, .reset, .tick_en, .cs1, .cfg, .tail, .head_load, .head_value,
      .head, .rd_en, .rd_addr, .rd_data, .audio
   );

   tape_mag_decoder u_decoder (
      .clk, .reset, .tick_en, .mag_in, .byte_valid, .byte_data
   );

   tape_byte_fifo #(.fifo_depth(fifo_depth)) u_fifo (
      .clk, .reset, .push(byte_valid), .push_entry, .pop,
      .head_entry(fifo_head), .empty(fifo_empty), .lost(fifo_lost)
   );

endmodule

/* tb_tape_mmio.sv */
`timescale 1ns/1ps

module tb_tape_mmio;

   localparam logic [13:0] reg_base = 14'h2000;   // addr[13] selects registers
   localparam logic [1:0]  reg_ctrl = 2'd0;
   localparam logic [1:0]  reg_ptrs = 2'd1;
   localparam logic [1:0]  reg_size = 2'd2;
   localparam logic [1:0]  reg_mag  = 2'd3;
   localparam int max_cycles = 20000;   // tests run a few thousand cycles

   logic               clk;
   logic               reset;
   logic               tick_en;
   logic               cs;
   logic               we;
   logic [3:0]         sel;
   logic [13:0]        addr;
   tape_pkg::word_t    wdata;
   tape_pkg::word_t    rdata;
   logic               cs1;
   logic               cs2;
   logic               mag_in;
   tape_pkg::sample_t  audio;

   int                 seed = 38;
   int                 cycle_count = 0;
   int                 error_count = 0;
   logic [15:0]        audio_log[$];
   logic [15:0]        expect_q[$];
   tape_pkg::word_t    words[$];
   logic [7:0]         frame[$];
   tape_pkg::sample_t  last_audio = '0;

   tape_mmio dut (
      .clk, .reset, .tick_en, .cs, .we, .sel, .addr, .wdata, .rdata,
      .cs1, .cs2, .mag_in, .audio
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(negedge clk) begin
      if (audio !== last_audio) begin   // log every change of the output
         audio_log.push_back(audio);
         last_audio = audio;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: the run did not finish within %0d cycles", max_cycles);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] time %0t %s got %h expected %h", $time, what, actual, expected);
         $display("Verification failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic bus_write(input logic [13:0] a, input tape_pkg::word_t d,
                            input logic [3:0] s);
      cs    = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      sel   = s;
      @(posedge clk);
      #10;
      cs    = 1'b0;
      we    = 1'b0;
      sel   = 4'h0;
   endtask

   task automatic bus_read(input logic [13:0] a, output tape_pkg::word_t d);
      cs   = 1'b1;
      we   = 1'b0;
      addr = a;
      sel  = 4'hf;
      #80 d = rdata;                    // settled before the edge
      @(posedge clk);
      #10;
      cs   = 1'b0;
      sel  = 4'h0;
   endtask

   task automatic wait_samples(input int n);
      while (audio_log.size() < n) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic load_and_play(input int base, input int n, input logic [15:0] ctrl_bits);
      logic [13:0] head_w;
      logic [13:0] tail_w;
      head_w = 14'(base);
      tail_w = 14'(base + n);
      for (int i = 0; i < n; i++)
         bus_write(14'(base + i), words[i], 4'hf);
      bus_write(reg_base | reg_ptrs, {2'b00, tail_w, 2'b00, head_w}, 4'hf);
      bus_write(reg_base | reg_ctrl, {16'h0, ctrl_bits}, 4'b0011);
   endtask

   task automatic stop_play();
      bus_write(reg_base | reg_ctrl, 32'h0, 4'b0011);
      idle(3);
      check_eq(audio, 0, "audio after playing cleared");
      audio_log.delete();
   endtask

   task automatic check_log(input string name);
      wait_samples(expect_q.size());
      idle(8);                          // no extra samples may follow
      check_eq(audio_log.size(), expect_q.size(), {name, " sample count"});
      foreach (expect_q[i])
         check_eq(audio_log[i], expect_q[i], $sformatf("%s sample %0d", name, i));
   endtask

   task automatic mag_toggle(input int hold);
      mag_in = ~mag_in;
      idle(hold);
   endtask

   task automatic mag_bit(input logic b);
      if (b) begin
         mag_toggle(3);
         mag_toggle(3);
      end else begin
         mag_toggle(8);
      end
   endtask

   task automatic send_frame();
      repeat (36)
         mag_bit(1'b0);                 // leader of zeros
      mag_bit(1'b1);
      foreach (frame[i])
         for (int j = 7; j >= 0; j--)
            mag_bit(frame[i][j]);
      mag_toggle(16);                   // closing edge, then quiet line
   endtask

   task automatic test_reset_regs();
      tape_pkg::word_t d;
      bus_read(reg_base | reg_ctrl, d);
      check_eq(d, 32'h0000_07ff, "ctrl after reset");
      bus_read(reg_base | reg_ptrs, d);
      check_eq(d, 32'h0, "ptrs after reset");
      bus_read(reg_base | reg_size, d);
      check_eq(d, 32'd2048, "size readback");
      bus_write(reg_base | reg_ctrl, 32'h0000_6123, 4'b0011);
      bus_read(reg_base | reg_ctrl, d);
      check_eq(d, 32'h0000_6123, "ctrl readback");
      bus_write(reg_base | reg_ptrs, 32'h2abc_0000, 4'b1100);
      bus_read(reg_base | reg_ptrs, d);
      check_eq(d, 32'h2abc_0000, "tail readback");
      bus_write(reg_base | reg_ctrl, 32'h0, 4'b0011);
      bus_write(reg_base | reg_ptrs, 32'h0, 4'hf);
   endtask

   task automatic test_mono16();
      logic [15:0]     h;
      logic [15:0]     prev;
      tape_pkg::word_t d;
      prev = 16'h0;
      expect_q.delete();
      words.delete();
      for (int i = 0; i < 8; i++) begin
         h = 16'($random(seed));
         if (h == prev)
            h = h ^ 16'h1;              // each sample must change the output
         expect_q.push_back(h);
         prev = h;
      end
      for (int i = 0; i < 4; i++)
         words.push_back({expect_q[2*i+1], expect_q[2*i]});
      load_and_play(0, 4, 16'ha002);
      check_log("mono16");
      bus_read(reg_base | reg_ptrs, d);
      check_eq(d[13:0], 14'd4, "head after mono16");
      stop_play();
   endtask

   task automatic test_mono8();
      logic [7:0] b[8];
      logic [7:0] prev;
      prev = 8'h0;
      expect_q.delete();
      words.delete();
      for (int i = 0; i < 8; i++) begin
         b[i] = 8'($random(seed));
         if (b[i] == prev)
            b[i] = b[i] ^ 8'h1;
         prev = b[i];
         expect_q.push_back({b[i] ^ 8'h80, b[i]});
      end
      words.push_back({b[3], b[2], b[1], b[0]});
      words.push_back({b[7], b[6], b[5], b[4]});
      load_and_play(4, 2, 16'h8001);
      check_log("mono8");
      stop_play();
   endtask

   task automatic test_stereo();
      logic [15:0] lo;
      logic [15:0] hi;
      logic [15:0] prev;
      prev = 16'h0;
      expect_q.delete();
      words.delete();
      for (int i = 0; i < 4; i++) begin
         lo = 16'($random(seed));
         hi = 16'($random(seed));
         if (16'(lo + hi) == prev)
            hi = hi ^ 16'h1;
         prev = lo + hi;                // wraps to 16 bits
         expect_q.push_back(prev);
         words.push_back({hi, lo});
      end
      load_and_play(6, 4, 16'he001);
      check_log("stereo");
      stop_play();
   endtask

   task automatic test_motor_mute();
      words.delete();
      words.push_back(32'($random(seed)));
      words.push_back(32'($random(seed)));
      if (words[0][15:0] == 16'h0)
         words[0][15:0] = 16'h1;
      if (words[0][31:16] == 16'h0)
         words[0][31:16] = 16'h1;
      cs1 = 1'b1;
      load_and_play(10, 2, 16'ha00f);
      wait_samples(1);
      check_eq(audio_log[0], words[0][15:0], "first sample before motor off");
      cs1 = 1'b0;                       // long before the next sample is due
      idle(40);
      check_eq(audio_log.size(), 2, "samples with motor off");
      check_eq(audio_log[1], 0, "audio muted by motor off");
      check_eq(audio, 0, "audio with motor off");
      cs1 = 1'b1;
      wait_samples(3);
      check_eq(audio_log[2], words[0][31:16], "sample after motor on");
      stop_play();
   endtask

   task automatic test_mag_capture();
      tape_pkg::word_t d;
      cs1 = 1'b1;
      cs2 = 1'b0;
      frame.delete();
      frame.push_back(8'ha5);
      frame.push_back(8'h3c);
      frame.push_back(8'hf0);
      send_frame();
      foreach (frame[i]) begin
         bus_read(reg_base | reg_mag, d);
         check_eq(d, 32'h1500 | frame[i], $sformatf("mag byte %0d", i));
      end
      bus_read(reg_base | reg_mag, d);
      check_eq(d[8], 1'b0, "valid after last byte");
   endtask

   task automatic test_fifo_overflow();
      tape_pkg::word_t d;
      frame.delete();
      for (int i = 0; i < 10; i++)
         frame.push_back(8'(i * 37 + 11));
      send_frame();
      for (int i = 0; i < 8; i++) begin
         bus_read(reg_base | reg_mag, d);
         check_eq(d, 32'h1500 | (i == 0 ? 32'h200 : 32'h0) | frame[i],
                  $sformatf("overflow byte %0d", i));
      end
      bus_read(reg_base | reg_mag, d);
      check_eq(d[9:8], 2'b00, "valid and lost after draining");
   endtask

   initial begin
      reset   = 1'b1;
      tick_en = 1'b1;
      cs      = 1'b0;
      we      = 1'b0;
      sel     = 4'h0;
      addr    = '0;
      wdata   = '0;
      cs1     = 1'b1;
      cs2     = 1'b0;
      mag_in  = 1'b0;
      repeat (8) @(posedge clk);
      #10;
      reset = 1'b0;
      idle(2);
      audio_log.delete();
      test_reset_regs();
      test_mono16();
      test_mono8();
      test_stereo();
      test_motor_mute();
      test_mag_capture();
      test_fifo_overflow();
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* tb.f */
tape_pkg.sv
tape_regs.sv
tape_sample_ram.sv
tape_player.sv
tape_mag_decoder.sv
tape_byte_fifo.sv
tape_mmio.sv
tb_tape_mmio.sv

/* Bender.yml */
package:
  name: tape_mmio

sources:
  - tape_pkg.sv
  - tape_regs.sv
  - tape_sample_ram.sv
  - tape_player.sv
  - tape_mag_decoder.sv
  - tape_byte_fifo.sv
  - tape_mmio.sv
  - target: test
    files:
      - tb_tape_mmio.sv
